//--- include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// integer datapath width
`define XLEN 32

// register file holds 2**REG_ADDR_W registers
`define REG_ADDR_W 5

// data memory depth in 32 bit words
`define DMEM_WORDS 64

`endif

//--- project.f
+incdir+include
verilog/common.sv
verilog/register_file.sv
verilog/decode_issue.sv
verilog/alu.sv
verilog/forwarding_unit.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/exec_backend.sv
verif/exec_backend_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module exec_backend_tb -f project.f -o exec_backend_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/exec_backend_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qxF 'All tests passed!'; then
  exit 0
fi
exit 1

//--- verif/exec_backend_tb.sv
`default_nettype none
`include "core_defines.svh"

module exec_backend_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import common::*;

  localparam int clk_period    = 40;
  localparam int reset_cycles  = 8;
  localparam int test_cycles   = 290 + 90 + 20 + 100 + 50;  // rough length of the five tests
  localparam int margin_cycles = 200;
  localparam int dmem_index_w  = $clog2(`DMEM_WORDS);

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   issue_valid;
  control_type            issue_control;
  logic [`REG_ADDR_W-1:0] issue_rs1;
  logic [`REG_ADDR_W-1:0] issue_rs2;
  logic [`REG_ADDR_W-1:0] issue_rd;
  logic [`XLEN-1:0]       issue_imm;
  logic [`XLEN-1:0]       issue_pc;
  logic                   ex_zero;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;
  logic [`XLEN-1:0]       wb_pc;

  logic [`XLEN-1:0]       model_regs [2**`REG_ADDR_W];
  logic [`XLEN-1:0]       model_mem [`DMEM_WORDS];
  logic [`REG_ADDR_W-1:0] exp_rd_q [$];
  logic [`XLEN-1:0]       exp_data_q [$];
  logic [`XLEN-1:0]       exp_pc_q [$];
  int                     exp_cycle_q [$];
  int                     wb_expected_cycle;
  int                     cycle_count = 0;
  int                     check_count = 0;
  int                     error_count = 0;
  integer                 seed = 32'h2cf3;
  logic [`XLEN-1:0]       next_pc = '0;

  exec_backend dut_i (
    .clk           (clk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_control (issue_control),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_pc      (issue_pc),
    .ex_zero       (ex_zero),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_pc         (wb_pc)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;  // edge count, read between edges for latency checks
  end

  task automatic check_value(input string name, input logic [`XLEN-1:0] actual,
                             input logic [`XLEN-1:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERR %s actual %h expected %h at %0t ns", name, actual, expected, $time);
    end
  endtask

  // reference ALU written from the RV32I definitions
  function automatic logic [`XLEN-1:0] ref_alu(input alu_op_type op, input logic [`XLEN-1:0] a,
                                              input logic [`XLEN-1:0] b);
    logic [4:0]       sh;
    logic [`XLEN-1:0] fill;
    logic             less;
    sh   = b[4:0];
    fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;  // ones shifted in for a negative value
    less = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a + ~b + 1;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_sll:  return a << sh;
      alu_srl:  return a >> sh;
      alu_sra:  return (a >> sh) | fill;
      alu_slt:  return `XLEN'(less);
      alu_sltu: return `XLEN'(a < b);
      default:  return '0;
    endcase
  endfunction

  function automatic control_type make_control(input alu_op_type op, input logic alu_src,
                                               input logic mem_read, input logic mem_write,
                                               input logic reg_write, input logic mem_to_reg);
    control_type c;
    c.alu_op     = op;
    c.alu_src    = alu_src;
    c.mem_read   = mem_read;
    c.mem_write  = mem_write;
    c.reg_write  = reg_write;
    c.mem_to_reg = mem_to_reg;
    return c;
  endfunction

  function automatic logic [`XLEN-1:0] random_word();
    return $random(seed);
  endfunction

  function automatic logic [`REG_ADDR_W-1:0] random_reg();
    logic [`XLEN-1:0] r;
    r = $random(seed);
    return (r[`REG_ADDR_W-1:0] == '0) ? `REG_ADDR_W'(1) : r[`REG_ADDR_W-1:0];
  endfunction

  function automatic logic [`REG_ADDR_W-1:0] random_small_reg();
    logic [`XLEN-1:0] r;
    r = $random(seed);
    return `REG_ADDR_W'(1 + r[1:0]);  // x1 to x4, keeps chains dense
  endfunction

  task automatic idle_cycles(input int n);
    issue_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // drives one instruction for a cycle and updates the model in program order
  task automatic issue_instr(input control_type ctrl, input logic [`REG_ADDR_W-1:0] rs1,
                             input logic [`REG_ADDR_W-1:0] rs2,
                             input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] imm);
    logic [`XLEN-1:0] right;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] wb_value;
    right  = ctrl.alu_src ? imm : model_regs[rs2];
    result = ref_alu(ctrl.alu_op, model_regs[rs1], right);
    if (ctrl.mem_write) begin
      model_mem[result[dmem_index_w+1:2]] = model_regs[rs2];
    end
    wb_value = ctrl.mem_to_reg ? model_mem[result[dmem_index_w+1:2]] : result;
    if (ctrl.reg_write && rd != '0) begin
      model_regs[rd] = wb_value;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(wb_value);
      exp_pc_q.push_back(next_pc);
      exp_cycle_q.push_back(cycle_count + 3);  // three edges to the writeback port
    end
    issue_valid   = 1'b1;
    issue_control = ctrl;
    issue_rs1     = rs1;
    issue_rs2     = rs2;
    issue_rd      = rd;
    issue_imm     = imm;
    issue_pc      = next_pc;
    next_pc       = next_pc + 4;
    @(negedge clk);
    check_value("ex_zero", `XLEN'(ex_zero), `XLEN'(result == '0));
    issue_valid = 1'b0;
  endtask

  task automatic issue_reg(input alu_op_type op, input logic [`REG_ADDR_W-1:0] rd,
                           input logic [`REG_ADDR_W-1:0] rs1, input logic [`REG_ADDR_W-1:0] rs2);
    issue_instr(make_control(op, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0), rs1, rs2, rd, random_word());
  endtask

  task automatic issue_alu_imm(input alu_op_type op, input logic [`REG_ADDR_W-1:0] rd,
                               input logic [`REG_ADDR_W-1:0] rs1, input logic [`XLEN-1:0] imm);
    issue_instr(make_control(op, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), rs1, '0, rd, imm);
  endtask

  task automatic issue_load(input logic [`REG_ADDR_W-1:0] rd,
                            input logic [`REG_ADDR_W-1:0] base, input logic [`XLEN-1:0] offset);
    issue_instr(make_control(alu_add, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1), base, '0, rd, offset);
  endtask

  task automatic issue_store(input logic [`REG_ADDR_W-1:0] src,
                             input logic [`REG_ADDR_W-1:0] base, input logic [`XLEN-1:0] offset);
    issue_instr(make_control(alu_add, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0), base, src, '0, offset);
  endtask

  // compares every writeback with the oldest expected result
  task automatic watch_writeback();
    forever begin
      @(negedge clk);
      if (wb_valid) begin
        if (exp_rd_q.size() == 0) begin
          error_count++;
          $display("unexpected writeback to register %0d at %0t ns", wb_rd, $time);
        end else begin
          check_value("wb_rd", `XLEN'(wb_rd), `XLEN'(exp_rd_q.pop_front()));
          check_value("wb_data", wb_data, exp_data_q.pop_front());
          check_value("wb_pc", wb_pc, exp_pc_q.pop_front());
          wb_expected_cycle = exp_cycle_q.pop_front();
          check_value("wb_valid edge", `XLEN'(cycle_count), `XLEN'(wb_expected_cycle));
        end
      end
    end
  endtask

  task automatic drain_and_check(input string test_name);
    idle_cycles(6);
    if (exp_rd_q.size() != 0) begin
      error_count++;
      $display("%s: %0d expected writebacks never arrived", test_name, exp_rd_q.size());
      exp_rd_q.delete();
      exp_data_q.delete();
      exp_pc_q.delete();
      exp_cycle_q.delete();
    end
  endtask

  task automatic reset_and_alu_test();
    idle_cycles(4);
    check_value("wb_valid", `XLEN'(wb_valid), '0);
    for (int r = 1; r < 2**`REG_ADDR_W; r++) begin
      issue_alu_imm(alu_add, `REG_ADDR_W'(r), '0, random_word());  // registers are not reset
    end
    for (int k = 0; k < 10; k++) begin
      for (int n = 0; n < 3; n++) begin
        issue_reg(alu_op_type'(4'(k)), random_reg(), random_reg(), random_reg());
        idle_cycles(3);
        issue_alu_imm(alu_op_type'(4'(k)), random_reg(), random_reg(), random_word());
        idle_cycles(3);
      end
    end
    drain_and_check("reset and alu test");
  endtask

  task automatic dependency_test();
    issue_reg(alu_add, 5, 1, 2);
    issue_reg(alu_sub, 6, 5, 3);  // rs1 one back
    issue_reg(alu_xor, 7, 4, 6);  // rs2 one back
    idle_cycles(3);
    issue_reg(alu_add, 8, 1, 2);
    issue_reg(alu_or, 9, 3, 4);
    issue_reg(alu_and, 10, 8, 9);  // two back on the left, one back on the right
    idle_cycles(3);
    issue_alu_imm(alu_add, 11, 1, 32'h0000_0123);
    issue_reg(alu_xor, 12, 2, 3);
    issue_reg(alu_or, 13, 3, 4);
    issue_reg(alu_sll, 14, 11, 2);  // three back, read during the register write
    issue_reg(alu_sra, 15, 2, 11);
    idle_cycles(3);
    // Both forwarding stages hold x16 and x18, the younger value must win.
    issue_alu_imm(alu_add, 16, 0, random_word());
    issue_alu_imm(alu_add, 16, 0, random_word());
    issue_reg(alu_add, 17, 16, 16);
    issue_alu_imm(alu_add, 18, 0, 32'h11);
    issue_alu_imm(alu_add, 18, 0, 32'h22);
    issue_alu_imm(alu_add, 18, 0, 32'h33);
    issue_reg(alu_sub, 19, 18, 0);
    idle_cycles(3);
    for (int n = 0; n < 24; n++) begin
      if (n % 3 == 0) begin
        issue_alu_imm(alu_op_type'(4'(n % 10)), random_small_reg(), random_small_reg(),
                      random_word());
      end else begin
        issue_reg(alu_op_type'(4'(n % 10)), random_small_reg(), random_small_reg(),
                  random_small_reg());
      end
    end
    drain_and_check("dependency test");
  endtask

  task automatic x0_test();
    issue_alu_imm(alu_add, 0, 1, 32'h1234);  // dropped write, no writeback
    issue_alu_imm(alu_add, 20, 0, 32'h5);
    issue_reg(alu_or, 21, 0, 0);
    issue_reg(alu_sub, 0, 1, 2);
    issue_reg(alu_add, 22, 0, 1);
    idle_cycles(3);
    issue_reg(alu_add, 23, 0, 0);
    drain_and_check("x0 test");
  endtask

  task automatic load_store_test();
    logic [`XLEN-1:0] offset;
    issue_alu_imm(alu_add, 24, 0, 32'h40);  // base address
    issue_alu_imm(alu_add, 25, 0, random_word());
    issue_store(25, 24, 32'h8);  // store data from the previous instruction
    issue_alu_imm(alu_add, 26, 0, random_word());
    issue_store(26, 24, 32'hc);
    issue_reg(alu_xor, 27, 1, 2);
    issue_load(28, 24, 32'h8);
    issue_load(29, 24, 32'hc);
    issue_alu_imm(alu_add, 30, 0, 32'h1);
    issue_reg(alu_add, 31, 28, 29);  // x29 loaded two back
    issue_store(31, 24, 32'h10);
    idle_cycles(1);
    issue_load(1, 24, 32'h10);
    idle_cycles(1);
    issue_reg(alu_sub, 2, 1, 31);
    idle_cycles(3);
    for (int n = 0; n < 8; n++) begin
      offset = random_word() & 32'h0000_00fc;
      issue_store(random_reg(), 0, offset);
      idle_cycles(1);
      issue_load(random_reg(), 0, offset);
      idle_cycles(2);
    end
    drain_and_check("load and store test");
  endtask

  task automatic zero_flag_test();
    logic [`XLEN-1:0] value;
    value = random_word();
    issue_alu_imm(alu_add, 3, 0, value);
    issue_alu_imm(alu_add, 4, 0, value);
    issue_reg(alu_sub, 5, 3, 4);  // equal operands through both forwarding paths
    issue_reg(alu_xor, 6, 4, 3);
    issue_reg(alu_sltu, 7, 3, 4);
    issue_reg(alu_sub, 8, 3, 5);
    issue_alu_imm(alu_and, 9, 5, random_word());
    idle_cycles(2);
    for (int n = 0; n < 12; n++) begin
      issue_reg(alu_op_type'(4'(n % 10)), random_reg(), random_reg(), random_reg());
    end
    drain_and_check("zero flag test");
  endtask

  initial begin
    #((reset_cycles + test_cycles + margin_cycles) * clk_period);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue_control = '0;
    issue_rs1     = '0;
    issue_rs2     = '0;
    issue_rd      = '0;
    issue_imm     = '0;
    issue_pc      = '0;
    for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
      model_regs[i] = '0;
    end
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    fork
      watch_writeback();
    join_none
    reset_and_alu_test();
    dependency_test();
    x0_test();
    load_store_test();
    zero_flag_test();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none
`include "core_defines.svh"

module alu (
  input  common::alu_op_type control,
  input  logic [`XLEN-1:0]   left_operand,
  input  logic [`XLEN-1:0]   right_operand,
  output logic [`XLEN-1:0]   result,
  output logic               zero_flag
);

  import common::*;

  localparam int shamt_w = $clog2(`XLEN);

  logic [shamt_w-1:0] shift_amount;
  logic               less_signed;
  logic               less_unsigned;

  assign shift_amount  = right_operand[shamt_w-1:0];  // only the low bits count for shifts
  assign less_signed   = $signed(left_operand) < $signed(right_operand);
  assign less_unsigned = left_operand < right_operand;

  always_comb begin
    case (control)
      alu_add:  result = left_operand + right_operand;
      alu_sub:  result = left_operand - right_operand;
      alu_and:  result = left_operand & right_operand;
      alu_or:   result = left_operand | right_operand;
      alu_xor:  result = left_operand ^ right_operand;
      alu_sll:  result = left_operand << shift_amount;
      alu_srl:  result = left_operand >> shift_amount;
      alu_sra:  result = $signed(left_operand) >>> shift_amount;  // sign bit fills from the top
      alu_slt:  result = {{(`XLEN-1){1'b0}}, less_signed};
      alu_sltu: result = {{(`XLEN-1){1'b0}}, less_unsigned};
      default:  result = '0;
    endcase
  end

  // used by the branch unit outside this block
  assign zero_flag = (result == '0);

endmodule

`default_nettype wire

//--- verilog/common.sv
`default_nettype none

package common;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,  // signed compare
    alu_sltu = 4'd9   // unsigned compare
  } alu_op_type;

  typedef enum logic [1:0] {
    no_forward     = 2'd0,  // value read from the register file
    forward_ex_mem = 2'd1,  // alu result of the previous instruction
    forward_mem_wb = 2'd2   // writeback data of the instruction two back
  } mux_control_type;

  typedef struct packed {
    alu_op_type alu_op;
    logic       alu_src;     // right alu operand is the immediate
    logic       mem_read;    // word load
    logic       mem_write;   // word store of the rs2 value
    logic       reg_write;
    logic       mem_to_reg;  // writeback takes the load data
  } control_type;

endpackage

`default_nettype wire

//--- verilog/decode_issue.sv
`default_nettype none
`include "core_defines.svh"

module decode_issue (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue_valid,
  input  common::control_type    issue_control,
  input  logic [`REG_ADDR_W-1:0] issue_rs1,
  input  logic [`REG_ADDR_W-1:0] issue_rs2,
  input  logic [`REG_ADDR_W-1:0] issue_rd,
  input  logic [`XLEN-1:0]       issue_imm,
  input  logic [`XLEN-1:0]       issue_pc,
  input  logic                   wb_enable,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic [`XLEN-1:0]       wb_data,
  output common::control_type    control_out,
  output logic [`XLEN-1:0]       data1,
  output logic [`XLEN-1:0]       data2,
  output logic [`XLEN-1:0]       immediate_data,
  output logic [`REG_ADDR_W-1:0] rs1,
  output logic [`REG_ADDR_W-1:0] rs2,
  output logic [`REG_ADDR_W-1:0] rd,
  output logic [`XLEN-1:0]       pc
);

  import common::*;

  localparam control_type bubble_control = '0;  // no write, no memory access

  logic [`XLEN-1:0] read_data1;
  logic [`XLEN-1:0] read_data2;

  register_file register_file_i (
    .clk          (clk),
    .read_addr1   (issue_rs1),
    .read_addr2   (issue_rs2),
    .write_addr   (wb_rd),
    .write_enable (wb_enable),
    .write_data   (wb_data),
    .read_data1   (read_data1),
    .read_data2   (read_data2)
  );

  // id/ex control, an idle issue slot becomes a bubble
  always_ff @(posedge clk) begin
    if (reset || !issue_valid) begin
      control_out <= bubble_control;
    end else begin
      control_out <= issue_control;
    end
  end

  always_ff @(posedge clk) begin
    data1          <= read_data1;
    data2          <= read_data2;
    immediate_data <= issue_imm;
    rs1            <= issue_rs1;  // kept for the forwarding compare in execute
    rs2            <= issue_rs2;
    rd             <= issue_rd;
    pc             <= issue_pc;
  end

endmodule

`default_nettype wire

//--- verilog/exec_backend.sv
`default_nettype none
`include "core_defines.svh"

module exec_backend (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   issue_valid,
  input  common::control_type    issue_control,
  input  logic [`REG_ADDR_W-1:0] issue_rs1,
  input  logic [`REG_ADDR_W-1:0] issue_rs2,
  input  logic [`REG_ADDR_W-1:0] issue_rd,
  input  logic [`XLEN-1:0]       issue_imm,
  input  logic [`XLEN-1:0]       issue_pc,
  output logic                   ex_zero,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]       wb_pc
);

  import common::*;

  control_type            id_ex_control;
  logic [`XLEN-1:0]       id_ex_data1;
  logic [`XLEN-1:0]       id_ex_data2;
  logic [`XLEN-1:0]       id_ex_imm;
  logic [`REG_ADDR_W-1:0] id_ex_rs1;
  logic [`REG_ADDR_W-1:0] id_ex_rs2;
  logic [`REG_ADDR_W-1:0] id_ex_rd;
  logic [`XLEN-1:0]       id_ex_pc;

  control_type            ex_control;
  logic [`XLEN-1:0]       ex_alu_data;
  logic [`XLEN-1:0]       ex_store_data;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic [`XLEN-1:0]       ex_pc;

  logic [`REG_ADDR_W-1:0] ex_mem_rd;
  logic                   ex_mem_reg_write;
  logic [`XLEN-1:0]       forward_ex_mem;
  logic [`REG_ADDR_W-1:0] mem_wb_rd;
  logic                   mem_wb_reg_write;

  decode_issue decode_issue_i (
    .clk            (clk),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue_control  (issue_control),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .issue_rd       (issue_rd),
    .issue_imm      (issue_imm),
    .issue_pc       (issue_pc),
    .wb_enable      (wb_valid),  // writeback port doubles as the register write
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .control_out    (id_ex_control),
    .data1          (id_ex_data1),
    .data2          (id_ex_data2),
    .immediate_data (id_ex_imm),
    .rs1            (id_ex_rs1),
    .rs2            (id_ex_rs2),
    .rd             (id_ex_rd),
    .pc             (id_ex_pc)
  );

  execute_stage execute_stage_i (
    .clk              (clk),
    .pc               (id_ex_pc),
    .control_in       (id_ex_control),
    .data1            (id_ex_data1),
    .data2            (id_ex_data2),
    .immediate_data   (id_ex_imm),
    .rs1              (id_ex_rs1),
    .rs2              (id_ex_rs2),
    .rd_in            (id_ex_rd),
    .ex_mem_rd        (ex_mem_rd),
    .mem_wb_rd        (mem_wb_rd),
    .ex_mem_reg_write (ex_mem_reg_write),
    .mem_wb_reg_write (mem_wb_reg_write),
    .forward_ex_mem   (forward_ex_mem),
    .forward_mem_wb   (wb_data),
    .control_out      (ex_control),
    .zero_flag        (ex_zero),
    .alu_data         (ex_alu_data),
    .memory_data      (ex_store_data),
    .rd_out           (ex_rd),
    .pc_out           (ex_pc)
  );

  memory_stage memory_stage_i (
    .clk              (clk),
    .reset            (reset),
    .control_in       (ex_control),
    .alu_data         (ex_alu_data),
    .memory_data      (ex_store_data),
    .rd_in            (ex_rd),
    .pc_in            (ex_pc),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_reg_write (ex_mem_reg_write),
    .forward_ex_mem   (forward_ex_mem),
    .mem_wb_rd        (mem_wb_rd),
    .mem_wb_reg_write (mem_wb_reg_write),
    .wb_valid         (wb_valid),
    .wb_rd            (wb_rd),
    .wb_data          (wb_data),
    .wb_pc            (wb_pc)
  );

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none
`include "core_defines.svh"

module execute_stage (
  input  logic                   clk,
  input  logic [`XLEN-1:0]       pc,
  input  common::control_type    control_in,
  input  logic [`XLEN-1:0]       data1,
  input  logic [`XLEN-1:0]       data2,
  input  logic [`XLEN-1:0]       immediate_data,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  logic [`REG_ADDR_W-1:0] rd_in,
  input  logic [`REG_ADDR_W-1:0] ex_mem_rd,
  input  logic [`REG_ADDR_W-1:0] mem_wb_rd,
  input  logic                   ex_mem_reg_write,
  input  logic                   mem_wb_reg_write,
  input  logic [`XLEN-1:0]       forward_ex_mem,   // alu result held in ex/mem
  input  logic [`XLEN-1:0]       forward_mem_wb,   // writeback data of mem/wb
  output common::control_type    control_out,
  output logic                   zero_flag,
  output logic [`XLEN-1:0]       alu_data,
  output logic [`XLEN-1:0]       memory_data,
  output logic [`REG_ADDR_W-1:0] rd_out,
  output logic [`XLEN-1:0]       pc_out
);

  import common::*;

  logic [`XLEN-1:0] left_operand;
  logic [`XLEN-1:0] rs2_value;      // forwarded rs2, also the store data
  logic [`XLEN-1:0] right_operand;
  mux_control_type  mux_ctrl_left;
  mux_control_type  mux_ctrl_right;

  forwarding_unit forwarding_unit_i (
    .rs1              (rs1),
    .rs2              (rs2),
    .ex_mem_rd        (ex_mem_rd),
    .mem_wb_rd        (mem_wb_rd),
    .ex_mem_reg_write (ex_mem_reg_write),
    .mem_wb_reg_write (mem_wb_reg_write),
    .mux_ctrl_left    (mux_ctrl_left),
    .mux_ctrl_right   (mux_ctrl_right)
  );

  always_comb begin
    case (mux_ctrl_left)
      common::forward_ex_mem: left_operand = forward_ex_mem;
      common::forward_mem_wb: left_operand = forward_mem_wb;
      default:                left_operand = data1;
    endcase
    case (mux_ctrl_right)
      common::forward_ex_mem: rs2_value = forward_ex_mem;
      common::forward_mem_wb: rs2_value = forward_mem_wb;
      default:                rs2_value = data2;
    endcase
    right_operand = control_in.alu_src ? immediate_data : rs2_value;  // the immediate only feeds the alu
  end

  alu alu_i (
    .control       (control_in.alu_op),
    .left_operand  (left_operand),
    .right_operand (right_operand),
    .result        (alu_data),
    .zero_flag     (zero_flag)
  );

  assign memory_data = rs2_value;
  assign control_out = control_in;
  assign rd_out      = rd_in;
  assign pc_out      = pc;

  // Load data reaches execute no earlier than two instructions later, so the
  // issuer must not hand a loaded register to the very next instruction.
  assert property (@(posedge clk)
    (control_in.mem_read && control_in.reg_write && rd_in != '0) |=>
      (control_in == '0) ||
      (rs1 != $past(rd_in) &&
       (rs2 != $past(rd_in) || (control_in.alu_src && !control_in.mem_write))))
    else $error("execute_stage: load result used by the next instruction");

endmodule

`default_nettype wire

//--- verilog/forwarding_unit.sv
`default_nettype none
`include "core_defines.svh"

module forwarding_unit (
  input  logic [`REG_ADDR_W-1:0]  rs1,
  input  logic [`REG_ADDR_W-1:0]  rs2,
  input  logic [`REG_ADDR_W-1:0]  ex_mem_rd,
  input  logic [`REG_ADDR_W-1:0]  mem_wb_rd,
  input  logic                    ex_mem_reg_write,
  input  logic                    mem_wb_reg_write,
  output common::mux_control_type mux_ctrl_left,
  output common::mux_control_type mux_ctrl_right
);

  import common::*;

  logic ex_mem_writes;
  logic mem_wb_writes;

  // a write to x0 never produces a value worth forwarding
  assign ex_mem_writes = ex_mem_reg_write && (ex_mem_rd != '0);
  assign mem_wb_writes = mem_wb_reg_write && (mem_wb_rd != '0);

  function automatic mux_control_type select_source(input logic [`REG_ADDR_W-1:0] source);
    if (ex_mem_writes && ex_mem_rd == source) begin
      return forward_ex_mem;  // the younger result wins
    end else if (mem_wb_writes && mem_wb_rd == source) begin
      return forward_mem_wb;
    end
    return no_forward;
  endfunction

  always_comb begin
    mux_ctrl_left  = select_source(rs1);
    mux_ctrl_right = select_source(rs2);
  end

  always_comb begin
    if (mux_ctrl_left != no_forward) begin
      assert (rs1 != '0) else $error("forwarding_unit: forward selected for rs1 = x0");
    end
    if (mux_ctrl_right != no_forward) begin
      assert (rs2 != '0) else $error("forwarding_unit: forward selected for rs2 = x0");
    end
  end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`default_nettype none
`include "core_defines.svh"

module memory_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  common::control_type    control_in,
  input  logic [`XLEN-1:0]       alu_data,
  input  logic [`XLEN-1:0]       memory_data,
  input  logic [`REG_ADDR_W-1:0] rd_in,
  input  logic [`XLEN-1:0]       pc_in,
  output logic [`REG_ADDR_W-1:0] ex_mem_rd,
  output logic                   ex_mem_reg_write,
  output logic [`XLEN-1:0]       forward_ex_mem,
  output logic [`REG_ADDR_W-1:0] mem_wb_rd,
  output logic                   mem_wb_reg_write,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]       wb_pc
);

  import common::*;

  localparam int dmem_index_w = $clog2(`DMEM_WORDS);

  control_type             ex_mem_control;
  logic [`XLEN-1:0]        ex_mem_alu_data;
  logic [`XLEN-1:0]        ex_mem_store_data;
  logic [`XLEN-1:0]        ex_mem_pc;
  control_type             mem_wb_control;
  logic [`XLEN-1:0]        mem_wb_alu_data;
  logic [`XLEN-1:0]        mem_wb_load_data;
  logic [`XLEN-1:0]        mem_wb_pc;
  logic [`XLEN-1:0]        data_memory [`DMEM_WORDS];
  logic [dmem_index_w-1:0] word_index;
  logic [`XLEN-1:0]        load_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_control <= '0;
      mem_wb_control <= '0;
    end else begin
      ex_mem_control <= control_in;
      mem_wb_control <= ex_mem_control;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_alu_data   <= alu_data;
    ex_mem_store_data <= memory_data;
    ex_mem_rd         <= rd_in;
    ex_mem_pc         <= pc_in;
  end

  // word addressed, the two byte offset bits are dropped
  assign word_index = ex_mem_alu_data[dmem_index_w+1:2];
  assign load_data  = data_memory[word_index];

  always_ff @(posedge clk) begin
    if (ex_mem_control.mem_write) begin
      data_memory[word_index] <= ex_mem_store_data;
    end
  end

  always_ff @(posedge clk) begin
    mem_wb_alu_data  <= ex_mem_alu_data;
    mem_wb_load_data <= load_data;
    mem_wb_rd        <= ex_mem_rd;
    mem_wb_pc        <= ex_mem_pc;
  end

  assign ex_mem_reg_write = ex_mem_control.reg_write;
  assign forward_ex_mem   = ex_mem_alu_data;  // a load value is not ready here yet
  assign mem_wb_reg_write = mem_wb_control.reg_write;

  assign wb_valid = mem_wb_control.reg_write && (mem_wb_rd != '0);
  assign wb_rd    = mem_wb_rd;
  assign wb_data  = mem_wb_control.mem_to_reg ? mem_wb_load_data : mem_wb_alu_data;
  assign wb_pc    = mem_wb_pc;

  assert property (@(posedge clk) disable iff (reset)
    !(ex_mem_control.mem_read && ex_mem_control.mem_write))
    else $error("memory_stage: load and store in the same instruction");

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none
`include "core_defines.svh"

module register_file (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] read_addr1,
  input  logic [`REG_ADDR_W-1:0] read_addr2,
  input  logic [`REG_ADDR_W-1:0] write_addr,
  input  logic                   write_enable,
  input  logic [`XLEN-1:0]       write_data,
  output logic [`XLEN-1:0]       read_data1,
  output logic [`XLEN-1:0]       read_data2
);

  logic [`XLEN-1:0] registers [1:2**`REG_ADDR_W-1];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (write_enable && write_addr != '0) begin
      registers[write_addr] <= write_data;
    end
  end

  always_comb begin
    if (read_addr1 == '0) begin
      read_data1 = '0;
    end else if (write_enable && write_addr == read_addr1) begin
      read_data1 = write_data;  // bypass the value written at the coming edge
    end else begin
      read_data1 = registers[read_addr1];
    end
  end

  always_comb begin
    if (read_addr2 == '0) begin
      read_data2 = '0;
    end else if (write_enable && write_addr == read_addr2) begin
      read_data2 = write_data;
    end else begin
      read_data2 = registers[read_addr2];
    end
  end

  // x0 reads as zero even while the writeback targets x0
  assert property (@(posedge clk)
    (read_addr1 != '0 || read_data1 == '0) && (read_addr2 != '0 || read_data2 == '0))
    else $error("register_file: x0 read back nonzero");

endmodule

`default_nettype wire
